// ==== acl_input_vectors.txt ====
# Column 1: measurement word in hex, X Y Z T from the top 16 bits down
# Column 2: status byte in hex, bit 4 activity, bit 5 inactivity, bit 6 awake
0000000000000000 00
0123456789ABCDEF 10
FEDCBA9876543210 20
FFFFFFFFFFFFFFFF 40
8000800080008000 70
7FFF7FFF7FFF7FFF 50
00010002000300F1 30
FF9C00640FA0001A 60
ABCDEF0012345678 8F
A5A55A5AC3C33C3C 0F
0F0F F0F0 skip

// ==== project.f ====
acl_readout_pkg.sv
reading_formatter.sv
status_tracker.sv
uart_line_sender.sv
acl_readout_top.sv
tb_acl_readout.sv

// ==== tb_acl_readout.sv ====
// Testbench for the accelerometer readout top level
// Drives records from a data file and checks the decoded UART line
`timescale 1ns/1ps
`default_nettype none

module tb_acl_readout;

  import acl_readout_pkg::*;

  logic s_clk_20mhz;
  logic s_rst_20mhz;
  acl_meas_t s_meas;
  logic s_meas_valid;
  logic [7:0] s_status;
  logic s_tx_go;
  logic s_uart_tx;
  logic s_tx_busy;
  logic s_activity;
  logic s_inactivity;

  // Records read from the stimulus file
  logic [63:0] rec_meas_q[$];
  logic [7:0] rec_status_q[$];
  // Expected line and line seen on the wire
  logic [7:0] exp_line [ACL_LINE_CHARS];
  logic [7:0] rx_line [ACL_LINE_CHARS];
  integer seed;

  acl_readout_top i_dut (
    .i_clk        (s_clk_20mhz),
    .i_rst        (s_rst_20mhz),
    .i_meas       (s_meas),
    .i_meas_valid (s_meas_valid),
    .i_status     (s_status),
    .i_tx_go      (s_tx_go),
    .o_uart_tx    (s_uart_tx),
    .o_tx_busy    (s_tx_busy),
    .o_activity   (s_activity),
    .o_inactivity (s_inactivity)
  );

  // 50 ns period
  initial begin
    s_clk_20mhz = 1'b0;
    forever #25 s_clk_20mhz = ~s_clk_20mhz;
  end

  // --------------------------------------------------
  // Error handling and checks
  // --------------------------------------------------
  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("RESULT: FAIL");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_value(input string test_name, input logic [63:0] expected,
                             input logic [63:0] actual);
    assert (actual === expected) else begin
      fail_run($sformatf("[ERROR] %s expected %0h actual %0h", test_name, expected, actual));
    end
  endtask

  function automatic logic flag_value(input bit inact);
    return inact ? s_inactivity : s_activity;
  endfunction

  // Label, four digits, space per field, then status letters, padding, CR LF
  task automatic build_expected(input logic [63:0] meas, input logic [7:0] status);
    logic [7:0] labels [4];
    logic [15:0] value;
    string digits;
    int pos;
    labels[0] = "X";
    labels[1] = "Y";
    labels[2] = "Z";
    labels[3] = "T";
    digits = "0123456789ABCDEF";
    pos = 0;
    for (int f = 0; f < 4; f++) begin
      value = meas[63 - 16 * f -: 16];
      exp_line[pos] = labels[f];
      for (int d = 0; d < 4; d++) begin
        exp_line[pos + 1 + d] = digits.getc(int'(value[15 - 4 * d -: 4]));
      end
      exp_line[pos + 5] = " ";
      pos = pos + 6;
    end
    exp_line[24] = status[STATUS_ACT_BIT] ? "A" : "-";
    exp_line[25] = status[STATUS_INACT_BIT] ? "I" : "-";
    exp_line[26] = status[STATUS_AWAKE_BIT] ? "W" : "-";
    for (int s = 27; s < 32; s++) begin
      exp_line[s] = " ";
    end
    exp_line[32] = 8'h0D;
    exp_line[33] = 8'h0A;
  endtask

  // --------------------------------------------------
  // Serial decode
  // --------------------------------------------------
  task automatic wait_start_bit(input string test_name);
    int count;
    count = 0;
    while (s_uart_tx !== 1'b0) begin
      @(negedge s_clk_20mhz);
      count++;
      if (count > 2 * FRAME_BITS * CLKS_PER_BIT) begin
        fail_run({test_name, ": no start bit arrived on the serial line"});
      end
    end
  endtask

  // Sample each bit near its middle
  task automatic receive_byte(output logic [7:0] data, input string test_name);
    wait_start_bit(test_name);
    repeat (CLKS_PER_BIT / 2) @(negedge s_clk_20mhz);
    check_value({test_name, " start bit"}, 64'd0, s_uart_tx);
    for (int b = 0; b < 8; b++) begin
      repeat (CLKS_PER_BIT) @(negedge s_clk_20mhz);
      data[b] = s_uart_tx;
    end
    repeat (CLKS_PER_BIT) @(negedge s_clk_20mhz);
    check_value({test_name, " stop bit"}, 64'd1, s_uart_tx);
  endtask

  task automatic receive_line(input string test_name);
    for (int i = 0; i < ACL_LINE_CHARS; i++) begin
      receive_byte(rx_line[i], $sformatf("%s byte %0d", test_name, i));
    end
  endtask

  task automatic wait_idle(input int limit, input string test_name);
    int count;
    count = 0;
    while (s_tx_busy !== 1'b0) begin
      @(negedge s_clk_20mhz);
      count++;
      if (count > limit) begin
        fail_run({test_name, ": busy did not fall after the line"});
      end
    end
  endtask

  // No extra frame may follow a finished line
  task automatic check_quiet(input string test_name);
    repeat (2 * FRAME_BITS * CLKS_PER_BIT) begin
      @(negedge s_clk_20mhz);
      check_value({test_name, " quiet line"}, 64'd1, s_uart_tx);
      check_value({test_name, " quiet busy"}, 64'd0, s_tx_busy);
    end
  endtask

  // --------------------------------------------------
  // One line with a stray strobe pair while busy
  // --------------------------------------------------
  task automatic run_line(input logic [63:0] meas, input logic [7:0] status,
                          input bit load, input string test_name);
    int gap;
    logic [63:0] junk;
    gap = 1 + ($unsigned($random(seed)) % 16);
    junk = {$random(seed), $random(seed)};
    build_expected(meas, status);
    repeat (gap) @(negedge s_clk_20mhz);
    if (load) begin
      s_meas = meas;
      s_meas_valid = 1'b1;
    end
    s_status = status;
    @(negedge s_clk_20mhz);
    s_meas_valid = 1'b0;
    @(negedge s_clk_20mhz);
    s_tx_go = 1'b1;
    @(negedge s_clk_20mhz);
    s_tx_go = 1'b0;
    s_status = 8'h00;
    // Busy and the start bit begin in the cycle after go
    check_value({test_name, " busy after go"}, 64'd1, s_tx_busy);
    check_value({test_name, " start after go"}, 64'd0, s_uart_tx);
    fork
      receive_line(test_name);
      begin
        // Lands inside the first frame
        repeat (500 + gap * 50) @(negedge s_clk_20mhz);
        check_value({test_name, " busy in flight"}, 64'd1, s_tx_busy);
        s_meas = junk;
        s_meas_valid = 1'b1;
        s_tx_go = 1'b1;
        @(negedge s_clk_20mhz);
        s_meas_valid = 1'b0;
        s_tx_go = 1'b0;
      end
    join
    for (int i = 0; i < ACL_LINE_CHARS; i++) begin
      check_value($sformatf("%s char %0d", test_name, i), exp_line[i], rx_line[i]);
    end
    wait_idle(2 * CLKS_PER_BIT, test_name);
    check_quiet(test_name);
  endtask

  // --------------------------------------------------
  // Flag stretching
  // --------------------------------------------------
  task automatic check_stretch(input bit inact, input string test_name);
    int count;
    logic [7:0] pattern;
    pattern = 8'h00;
    pattern[inact ? STATUS_INACT_BIT : STATUS_ACT_BIT] = 1'b1;
    check_value({test_name, " low before"}, 64'd0, flag_value(inact));
    s_status = pattern;
    @(negedge s_clk_20mhz);
    s_status = 8'h00;
    check_value({test_name, " raised"}, 64'd1, flag_value(inact));
    repeat (STRETCH_CYCLES - 1) @(negedge s_clk_20mhz);
    check_value({test_name, " held"}, 64'd1, flag_value(inact));
    count = 0;
    while (flag_value(inact) !== 1'b0) begin
      @(negedge s_clk_20mhz);
      count++;
      if (count > 4) begin
        fail_run({test_name, ": flag did not fall after the stretch time"});
      end
    end
  endtask

  initial begin
    int fd;
    int n;
    string text;
    logic [63:0] word;
    logic [7:0] st;
    s_rst_20mhz = 1'b1;
    s_meas = '0;
    s_meas_valid = 1'b0;
    s_status = 8'h00;
    s_tx_go = 1'b0;
    seed = 32'h7828;

    // Skip comment and blank lines
    fd = $fopen("acl_input_vectors.txt", "r");
    if (fd == 0) begin
      fail_run("Could not open the stimulus file acl_input_vectors.txt");
    end
    while (!$feof(fd)) begin
      text = "";
      n = $fgets(text, fd);
      if (n > 0 && text.len() > 1 && text.getc(0) != "#") begin
        n = $sscanf(text, "%h %h", word, st);
        if (n != 2) begin
          fail_run({"Malformed record in the stimulus file: ", text});
        end
        rec_meas_q.push_back(word);
        rec_status_q.push_back(st);
      end
    end
    $fclose(fd);
    if (rec_meas_q.size() == 0) begin
      fail_run("The stimulus file holds no records");
    end

    repeat (3) @(posedge s_clk_20mhz);
    @(negedge s_clk_20mhz);
    s_rst_20mhz = 1'b0;
    check_value("reset uart_tx", 64'd1, s_uart_tx);
    check_value("reset tx_busy", 64'd0, s_tx_busy);
    check_value("reset activity", 64'd0, s_activity);
    check_value("reset inactivity", 64'd0, s_inactivity);

    foreach (rec_meas_q[i]) begin
      run_line(rec_meas_q[i], rec_status_q[i], 1'b1, $sformatf("record %0d", i));
    end
    // Reading strobed while busy must not replace the last idle load
    run_line(rec_meas_q[rec_meas_q.size() - 1], 8'h00, 1'b0, "held reading");

    check_stretch(1'b0, "activity stretch");
    check_stretch(1'b1, "inactivity stretch");

    $display("RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

// ==== acl_readout_top.sv ====
// Accelerometer readout top level
// Formatter, status tracker and UART line sender
`timescale 1ns/1ps
`default_nettype none

module acl_readout_top (
  input  logic                        i_clk,
  input  logic                        i_rst,
  input  acl_readout_pkg::acl_meas_t  i_meas,
  input  logic                        i_meas_valid,
  input  logic [7:0]                  i_status,
  input  logic                        i_tx_go,
  output logic                        o_uart_tx,
  output logic                        o_tx_busy,
  output logic                        o_activity,
  output logic                        o_inactivity
);

  import acl_readout_pkg::*;

  // 20 MHz system clock and its synchronous reset
  logic s_clk_20mhz;
  logic s_rst_20mhz;

  // Sender idle, gates measurement loads
  logic s_line_idle;
  // Measurement text to the sender
  acl_text_t s_text;
  // Stretched and awake flags
  acl_flags_t s_flags;

  assign s_clk_20mhz = i_clk;
  assign s_rst_20mhz = i_rst;

  // --------------------------------------------------
  // Reading path
  // --------------------------------------------------
  reading_formatter u_reading_formatter (
    .i_clk        (s_clk_20mhz),
    .i_rst        (s_rst_20mhz),
    .i_meas       (i_meas),
    .i_meas_valid (i_meas_valid),
    .i_line_idle  (s_line_idle),
    .o_text       (s_text)
  );

  // Status decode and stretching
  status_tracker u_status_tracker (
    .i_clk    (s_clk_20mhz),
    .i_rst    (s_rst_20mhz),
    .i_status (i_status),
    .o_flags  (s_flags)
  );

  // Serial output of the assembled line
  uart_line_sender u_uart_line_sender (
    .i_clk       (s_clk_20mhz),
    .i_rst       (s_rst_20mhz),
    .i_tx_go     (i_tx_go),
    .i_text      (s_text),
    .i_flags     (s_flags),
    .o_line_idle (s_line_idle),
    .o_tx_busy   (o_tx_busy),
    .o_uart_tx   (o_uart_tx)
  );

  // Stretched flags brought out directly
  assign o_activity = s_flags.activity;
  assign o_inactivity = s_flags.inactivity;

endmodule

`default_nettype wire

// ==== uart_line_sender.sv ====
// Line assembly and transmit-only UART, 8N1
// Sends one 34-byte line per accepted go strobe
`timescale 1ns/1ps
`default_nettype none

module uart_line_sender (
  input  logic                        i_clk,
  input  logic                        i_rst,
  input  logic                        i_tx_go,
  input  acl_readout_pkg::acl_text_t  i_text,
  input  acl_readout_pkg::acl_flags_t i_flags,
  output logic                        o_line_idle,
  output logic                        o_tx_busy,
  output logic                        o_uart_tx
);

  import acl_readout_pkg::*;

  // Line in flight
  logic s_busy;
  // Go strobe taken only while idle
  logic s_go_accept;
  // Line built from the current text and flags
  acl_line_t s_line_next;
  // Snapshot, next byte to send sits in the top byte
  acl_line_t s_line_q;
  // Frame shift register, bit 0 drives the line
  logic [FRAME_BITS-1:0] s_frame_q;
  logic [BAUD_CNT_W-1:0] s_baud_cnt;
  logic [FRAME_CNT_W-1:0] s_bit_cnt;
  // Bytes completed in the current line
  logic [LINE_IDX_W-1:0] s_byte_idx;
  // End of one bit, one frame, whole line
  logic s_bit_end;
  logic s_frame_end;
  logic s_line_end;

  // --------------------------------------------------
  // Line assembly
  // --------------------------------------------------
  // Status letters become dashes when their flag is low
  assign s_line_next = {i_text,
                        i_flags.activity ? ASCII_A : ASCII_DASH,
                        i_flags.inactivity ? ASCII_I : ASCII_DASH,
                        i_flags.awake ? ASCII_W : ASCII_DASH,
                        {5{ASCII_SPACE}},
                        ASCII_CR,
                        ASCII_LF};

  assign s_go_accept = i_tx_go & ~s_busy;

  // Counter stays at zero while idle, so no bit end outside a line
  assign s_bit_end = (s_baud_cnt == BAUD_CNT_W'(CLKS_PER_BIT - 1));
  assign s_frame_end = s_bit_end & (s_bit_cnt == FRAME_CNT_W'(FRAME_BITS - 1));
  assign s_line_end = s_frame_end & (s_byte_idx == LINE_IDX_W'(ACL_LINE_CHARS - 1));

  // --------------------------------------------------
  // Serializer control
  // --------------------------------------------------
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      s_busy <= 1'b0;
      s_baud_cnt <= '0;
      s_bit_cnt <= '0;
      s_byte_idx <= '0;
      s_frame_q <= '1;
    end else if (s_go_accept) begin
      // Start bit goes out in the next cycle
      s_busy <= 1'b1;
      s_baud_cnt <= '0;
      s_bit_cnt <= '0;
      s_byte_idx <= '0;
      s_frame_q <= {1'b1, s_line_next[ACL_LINE_CHARS-1], 1'b0};
    end else if (s_busy) begin
      if (!s_bit_end) begin
        s_baud_cnt <= s_baud_cnt + 1'b1;
      end else begin
        s_baud_cnt <= '0;
        if (!s_frame_end) begin
          // Next bit of the same frame, LSB first
          s_bit_cnt <= s_bit_cnt + 1'b1;
          s_frame_q <= {1'b1, s_frame_q[FRAME_BITS-1:1]};
        end else begin
          s_bit_cnt <= '0;
          s_byte_idx <= s_byte_idx + 1'b1;
          if (s_line_end) begin
            // Last stop bit done, line returns to mark
            s_busy <= 1'b0;
            s_frame_q <= '1;
          end else begin
            // Back to back frames, no idle gap
            s_frame_q <= {1'b1, s_line_q[ACL_LINE_CHARS-2], 1'b0};
          end
        end
      end
    end
  end

  // Line snapshot, shifted up by one byte per finished frame
  always_ff @(posedge i_clk) begin
    if (s_go_accept) begin
      s_line_q <= s_line_next;
    end else if (s_frame_end) begin
      s_line_q <= {s_line_q[ACL_LINE_CHARS-2:0], ASCII_SPACE};
    end
  end

  assign o_uart_tx = s_frame_q[0];
  assign o_tx_busy = s_busy;
  assign o_line_idle = ~s_busy;

  // Serial line rests at mark between lines
  a_idle_mark : assert property (
    @(posedge i_clk) disable iff (i_rst)
    !s_busy |-> o_uart_tx
  );

  // Byte count stays within one line
  a_byte_idx_range : assert property (
    @(posedge i_clk) disable iff (i_rst)
    s_byte_idx <= LINE_IDX_W'(ACL_LINE_CHARS)
  );

endmodule

`default_nettype wire

// ==== status_tracker.sv ====
// Status register decode with activity and inactivity stretching
// Awake bit registered without stretching
`timescale 1ns/1ps
`default_nettype none

module status_tracker (
  input  logic                        i_clk,
  input  logic                        i_rst,
  input  logic [7:0]                  i_status,
  output acl_readout_pkg::acl_flags_t o_flags
);

  import acl_readout_pkg::*;

  // Slot 0 activity, slot 1 inactivity
  localparam int NUM_STRETCH = 2;

  // Raw status bits feeding the stretchers
  logic [NUM_STRETCH-1:0] s_stretch_in;
  // Counter nonzero per stretcher
  logic [NUM_STRETCH-1:0] s_stretch_flag;
  // Awake bit one cycle behind the register
  logic s_awake_q;

  // Decode by bit position
  assign s_stretch_in = {i_status[STATUS_INACT_BIT], i_status[STATUS_ACT_BIT]};

  // --------------------------------------------------
  // Stretch counters
  // --------------------------------------------------
  for (genvar g = 0; g < NUM_STRETCH; g++) begin : g_stretch
    logic [STRETCH_CNT_W-1:0] s_cnt;

    // Reload while the bit is high, then count down to zero
    always_ff @(posedge i_clk) begin
      if (i_rst) begin
        s_cnt <= '0;
      end else if (s_stretch_in[g]) begin
        s_cnt <= STRETCH_CNT_W'(STRETCH_CYCLES);
      end else if (s_cnt != '0) begin
        s_cnt <= s_cnt - 1'b1;
      end
    end

    assign s_stretch_flag[g] = (s_cnt != '0);

    // A high sample shows on the flag in the very next cycle
    a_flag_follows_bit : assert property (
      @(posedge i_clk) disable iff (i_rst)
      s_stretch_in[g] |=> s_stretch_flag[g]
    );
  end

  // --------------------------------------------------
  // Awake bit
  // --------------------------------------------------
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      s_awake_q <= 1'b0;
    end else begin
      s_awake_q <= i_status[STATUS_AWAKE_BIT];
    end
  end

  // Flag bundle for the sender and the top level
  assign o_flags.activity = s_stretch_flag[0];
  assign o_flags.inactivity = s_stretch_flag[1];
  assign o_flags.awake = s_awake_q;

endmodule

`default_nettype wire

// ==== reading_formatter.sv ====
// Measurement hold register and hex text formatter
// Loads a new reading only while the serial line is idle
`timescale 1ns/1ps
`default_nettype none

module reading_formatter (
  input  logic                        i_clk,
  input  logic                        i_rst,
  input  acl_readout_pkg::acl_meas_t  i_meas,
  input  logic                        i_meas_valid,
  input  logic                        i_line_idle,
  output acl_readout_pkg::acl_text_t  o_text
);

  import acl_readout_pkg::*;

  // --------------------------------------------------
  // Text helpers
  // --------------------------------------------------

  // One nibble to an upper case hex digit
  function automatic acl_char_t hex_char(input logic [3:0] nib);
    if (nib < 4'd10) begin
      return ASCII_ZERO + acl_char_t'(nib);
    end
    // Values 10 to 15 map onto A to F
    return ASCII_A + acl_char_t'(nib) - 8'd10;
  endfunction

  // Label, four hex digits of the value, trailing space
  function automatic acl_field_t field_text(input acl_char_t label,
                                            input logic [15:0] value);
    acl_field_t field;
    field[5] = label;
    field[4] = hex_char(value[15:12]);
    field[3] = hex_char(value[11:8]);
    field[2] = hex_char(value[7:4]);
    field[1] = hex_char(value[3:0]);
    field[0] = ASCII_SPACE;
    return field;
  endfunction

  // --------------------------------------------------
  // Measurement hold
  // --------------------------------------------------

  // Reading shown on the line
  acl_meas_t s_meas_held;
  // Strobe accepted only while no line is in flight
  logic s_meas_load;

  assign s_meas_load = i_meas_valid & i_line_idle;

  // Held value is zero out of reset
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      s_meas_held <= '0;
    end else if (s_meas_load) begin
      s_meas_held <= i_meas;
    end
  end

  // --------------------------------------------------
  // Text layout
  // --------------------------------------------------

  // X first, temperature last
  assign o_text = {field_text(ASCII_X, s_meas_held.x),
                   field_text(ASCII_Y, s_meas_held.y),
                   field_text(ASCII_Z, s_meas_held.z),
                   field_text(ASCII_T, s_meas_held.temp)};

  // Line in flight keeps its reading until the sender goes idle again
  a_hold_while_busy : assert property (
    @(posedge i_clk) disable iff (i_rst)
    !i_line_idle |=> $stable(s_meas_held)
  );

endmodule

`default_nettype wire

// ==== acl_readout_pkg.sv ====
// Shared types and constants of the accelerometer readout path
// Measurement, flag and line types, UART timing and ASCII codes
`default_nettype none

package acl_readout_pkg;

  // --------------------------------------------------
  // Line layout
  // --------------------------------------------------
  // One labelled field is a letter, four hex digits and a space
  localparam int ACL_FIELD_CHARS = 6;
  // Four fields in the order X, Y, Z, T
  localparam int ACL_TEXT_CHARS = 4 * ACL_FIELD_CHARS;
  // Text, three status letters, five spaces, CR and LF
  localparam int ACL_LINE_CHARS = 34;
  // Byte index also holds the final count of a finished line
  localparam int LINE_IDX_W = $clog2(ACL_LINE_CHARS + 1);

  // --------------------------------------------------
  // UART timing, 20 MHz / 115200 baud, 8N1
  // --------------------------------------------------
  localparam int CLKS_PER_BIT = 174;
  localparam int BAUD_CNT_W = $clog2(CLKS_PER_BIT);
  // Start bit, eight data bits, stop bit
  localparam int FRAME_BITS = 10;
  localparam int FRAME_CNT_W = $clog2(FRAME_BITS);

  // --------------------------------------------------
  // Status register decode
  // --------------------------------------------------
  // Hold time of a stretched flag after its last high sample
  localparam int STRETCH_CYCLES = 2000;
  localparam int STRETCH_CNT_W = $clog2(STRETCH_CYCLES + 1);
  localparam int STATUS_ACT_BIT = 4;
  localparam int STATUS_INACT_BIT = 5;
  localparam int STATUS_AWAKE_BIT = 6;

  // Single ASCII character
  typedef logic [7:0] acl_char_t;

  // ASCII codes shared by the formatter and the sender
  localparam acl_char_t ASCII_SPACE = 8'h20;
  localparam acl_char_t ASCII_CR = 8'h0D;
  localparam acl_char_t ASCII_LF = 8'h0A;
  localparam acl_char_t ASCII_DASH = 8'h2D;
  localparam acl_char_t ASCII_ZERO = 8'h30;
  // Letters for hex digits, field labels and status
  localparam acl_char_t ASCII_A = 8'h41;
  localparam acl_char_t ASCII_I = 8'h49;
  localparam acl_char_t ASCII_T = 8'h54;
  localparam acl_char_t ASCII_W = 8'h57;
  localparam acl_char_t ASCII_X = 8'h58;
  localparam acl_char_t ASCII_Y = 8'h59;
  localparam acl_char_t ASCII_Z = 8'h5A;

  // Measurement word, X in the top 16 bits
  typedef struct packed {
    logic signed [15:0] x;
    logic signed [15:0] y;
    logic signed [15:0] z;
    logic signed [15:0] temp;
  } acl_meas_t;

  // Stretched and live status flags
  typedef struct packed {
    logic activity;
    logic inactivity;
    logic awake;
  } acl_flags_t;

  // Text arrays, first character in the top byte
  typedef acl_char_t [ACL_FIELD_CHARS-1:0] acl_field_t;
  typedef acl_char_t [ACL_TEXT_CHARS-1:0] acl_text_t;
  typedef acl_char_t [ACL_LINE_CHARS-1:0] acl_line_t;

endpackage

`default_nettype wire
